// File: hdl/audio_pkg.sv
`default_nettype none

// Sample formats seen by the synthesizer side of the filter.
package audio_pkg;

    // ------------------------------------------------------------
    // Input samples
    // ------------------------------------------------------------
    localparam int sample_width = 9;

    // Left and right inputs, also the delay line contents.
    typedef logic signed [sample_width-1:0] sample_t;

    // ------------------------------------------------------------
    // Filtered output
    // ------------------------------------------------------------
    localparam int out_width = 25;

    typedef logic signed [out_width-1:0] out_t;  // Wraps modulo 2**25.

endpackage

`default_nettype wire

// File: hdl/fir_pkg.sv
`default_nettype none

// Geometry and arithmetic of the 73-tap symmetric low-pass FIR.
package fir_pkg;

    // ------------------------------------------------------------
    // Filter geometry
    // ------------------------------------------------------------
    localparam int taps        = 73;
    localparam int coeff_count = (taps + 1) / 2;  // Unique coefficients.
    localparam int last_coeff  = coeff_count - 1;  // Centre tap.

    typedef logic [$clog2(taps)-1:0]        tap_index_t;    // 7 bits.
    typedef logic [$clog2(coeff_count)-1:0] coeff_index_t;  // 6 bits.

    // ------------------------------------------------------------
    // Arithmetic widths
    // ------------------------------------------------------------
    localparam int coeff_width   = 9;
    localparam int product_width = audio_pkg::sample_width + 1 + coeff_width;
    localparam int acc_width     = audio_pkg::out_width;

    typedef logic signed [coeff_width-1:0] coeff_t;

    // Symmetric taps are added before the multiplier, one bit of growth.
    typedef logic signed [audio_pkg::sample_width:0] pair_sum_t;

    typedef logic signed [product_width-1:0] product_t;  // 19 bits.

    // Accumulator matches the output word and simply wraps.
    typedef logic signed [acc_width-1:0] acc_t;

    // ------------------------------------------------------------
    // Default low-pass table, outermost tap first
    // ------------------------------------------------------------
    localparam coeff_t coeff_defaults [coeff_count] = '{
        // Taps 0 to 9, small negative skirt.
        9'sd0,
        -9'sd1,
        -9'sd1,
        -9'sd2,
        -9'sd3,
        -9'sd3,
        -9'sd4,
        -9'sd4,
        -9'sd3,
        -9'sd1,
        // Taps 10 to 18, first positive lobe.
        9'sd1,
        9'sd3,
        9'sd7,
        9'sd10,
        9'sd12,
        9'sd13,
        9'sd12,
        9'sd9,
        9'sd3,
        // Taps 19 to 27, negative lobe.
        -9'sd5,
        -9'sd14,
        -9'sd24,
        -9'sd33,
        -9'sd40,
        -9'sd43,
        -9'sd39,
        -9'sd29,
        -9'sd12,
        // Taps 28 to 36, main lobe up to the centre.
        9'sd13,
        9'sd44,
        9'sd80,
        9'sd119,
        9'sd157,
        9'sd192,
        9'sd222,
        9'sd243,
        9'sd255
    };

endpackage

`default_nettype wire

// File: hdl/fir_coeff_regs.sv
`timescale 1ns/10ps
`default_nettype none

// Writable coefficient store for the FIR engine.
module fir_coeff_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  coeff_we,
    input  fir_pkg::coeff_index_t coeff_addr,
    input  fir_pkg::coeff_t       coeff_data,
    input  fir_pkg::coeff_index_t coeff_index,
    output fir_pkg::coeff_t       coeff_value
);

    fir_pkg::coeff_t coeffs [fir_pkg::coeff_count];
    logic            addr_ok;

    // Addresses past the table are dropped silently.
    assign addr_ok = (coeff_addr < fir_pkg::coeff_index_t'(fir_pkg::coeff_count));

    // ------------------------------------------------------------
    // Register file
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < fir_pkg::coeff_count; i++) begin
                coeffs[i] <= fir_pkg::coeff_defaults[i];  // Low-pass table.
            end
        end else if (coeff_we && addr_ok) begin
            coeffs[coeff_addr] <= coeff_data;  // Host write, takes effect at once.
        end
    end

    // Engine read port.
    assign coeff_value = coeffs[coeff_index];

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // The sequencer must stay inside the table on every cycle.
    coeff_index_in_range: assert property (
        @(posedge clk) disable iff (rst)
        coeff_index <= fir_pkg::coeff_index_t'(fir_pkg::last_coeff)
    ) else $error("coeff_index %0d past end of table", coeff_index);

endmodule

`default_nettype wire

// File: hdl/fir_delay_line.sv
`timescale 1ns/10ps
`default_nettype none

// Stereo sample history, newest sample at position 0.
module fir_delay_line (
    input  logic                clk,
    input  logic                rst,
    input  logic                shift,
    input  audio_pkg::sample_t  left_in,
    input  audio_pkg::sample_t  right_in,
    input  fir_pkg::tap_index_t fwd_index,
    input  fir_pkg::tap_index_t rev_index,
    output audio_pkg::sample_t  fwd_left,
    output audio_pkg::sample_t  rev_left,
    output audio_pkg::sample_t  fwd_right,
    output audio_pkg::sample_t  rev_right
);

    audio_pkg::sample_t chain_left  [fir_pkg::taps];
    audio_pkg::sample_t chain_right [fir_pkg::taps];

    // ------------------------------------------------------------
    // Shift chains
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < fir_pkg::taps; i++) begin
                chain_left[i]  <= '0;
                chain_right[i] <= '0;
            end
        end else if (shift) begin
            chain_left[0]  <= left_in;   // New pair enters here.
            chain_right[0] <= right_in;
            for (int i = 1; i < fir_pkg::taps; i++) begin
                chain_left[i]  <= chain_left[i-1];
                chain_right[i] <= chain_right[i-1];
            end
        end
    end

    // ------------------------------------------------------------
    // Tap read ports
    // ------------------------------------------------------------
    // Forward index walks up from the newest sample,
    // reverse index walks down from the oldest one.
    assign fwd_left  = chain_left[fwd_index];
    assign rev_left  = chain_left[rev_index];
    assign fwd_right = chain_right[fwd_index];
    assign rev_right = chain_right[rev_index];

endmodule

`default_nettype wire

// File: hdl/fir_mac_engine.sv
`timescale 1ns/10ps
`default_nettype none

// Time-shared multiply-accumulate for both channels.
module fir_mac_engine (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sample,
    input  audio_pkg::sample_t    fwd_left,
    input  audio_pkg::sample_t    rev_left,
    input  audio_pkg::sample_t    fwd_right,
    input  audio_pkg::sample_t    rev_right,
    input  fir_pkg::coeff_t       coeff_value,
    output logic                  shift,
    output fir_pkg::tap_index_t   fwd_index,
    output fir_pkg::tap_index_t   rev_index,
    output fir_pkg::coeff_index_t coeff_index,
    output audio_pkg::out_t       left_out,
    output audio_pkg::out_t       right_out,
    output logic                  sample_out,
    output logic                  overrun
);

    typedef enum logic [1:0] {
        IDLE,
        LEFT,
        RIGHT
    } state_t;

    state_t                state;
    logic                  sample_q;
    logic                  rise;        // Registered rising edge of sample.
    fir_pkg::coeff_index_t cnt;
    fir_pkg::tap_index_t   rev;
    fir_pkg::acc_t         acc;
    fir_pkg::acc_t         acc_next;
    logic                  last_stage;
    audio_pkg::sample_t    fwd_tap;
    audio_pkg::sample_t    rev_tap;
    fir_pkg::pair_sum_t    rev_term;
    fir_pkg::pair_sum_t    pair_sum;
    fir_pkg::product_t     product;

    // ------------------------------------------------------------
    // Sample edge detection
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            sample_q <= 1'b0;
            rise     <= 1'b0;
        end else begin
            sample_q <= sample;
            rise     <= sample & ~sample_q;
        end
    end

    // Only an idle engine accepts the new pair.
    assign shift = rise && (state == IDLE);

    // ------------------------------------------------------------
    // Pre-add and multiply
    // ------------------------------------------------------------
    assign last_stage = (cnt == fir_pkg::coeff_index_t'(fir_pkg::last_coeff));

    assign fwd_tap = (state == RIGHT) ? fwd_right : fwd_left;
    assign rev_tap = (state == RIGHT) ? rev_right : rev_left;

    // Centre tap has no partner.
    assign rev_term = last_stage ? fir_pkg::pair_sum_t'(0) : fir_pkg::pair_sum_t'(rev_tap);
    assign pair_sum = fir_pkg::pair_sum_t'(fwd_tap) + rev_term;

    assign product  = pair_sum * coeff_value;
    assign acc_next = acc + fir_pkg::acc_t'(product);  // Wraps at 25 bits.

    // ------------------------------------------------------------
    // Sequencer
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            cnt        <= '0;
            rev        <= fir_pkg::tap_index_t'(fir_pkg::taps - 1);
            acc        <= '0;
            left_out   <= '0;
            right_out  <= '0;
            sample_out <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            sample_out <= 1'b0;
            overrun    <= rise && (state != IDLE);  // Sample dropped while busy.
            case (state)
                IDLE: begin
                    if (rise) begin
                        state <= LEFT;
                        cnt   <= '0;
                        rev   <= fir_pkg::tap_index_t'(fir_pkg::taps - 1);
                        acc   <= '0;
                    end
                end
                LEFT, RIGHT: begin
                    if (last_stage) begin
                        cnt <= '0;
                        rev <= fir_pkg::tap_index_t'(fir_pkg::taps - 1);
                        acc <= '0;
                        if (state == LEFT) begin
                            left_out <= acc_next;
                            state    <= RIGHT;
                        end else begin
                            right_out  <= acc_next;
                            sample_out <= 1'b1;  // Both channels ready.
                            state      <= IDLE;
                        end
                    end else begin
                        acc <= acc_next;
                        cnt <= cnt + 1'b1;
                        rev <= rev - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign fwd_index   = fir_pkg::tap_index_t'(cnt);
    assign rev_index   = rev;
    assign coeff_index = cnt;

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // One strobe per finished frame.
    sample_out_single: assert property (
        @(posedge clk) disable iff (rst)
        sample_out |=> !sample_out
    ) else $error("sample_out high for two cycles");

    // A shift starts the left pass at tap 0 with a cleared accumulator.
    shift_starts_left: assert property (
        @(posedge clk) disable iff (rst)
        shift |=> (state == LEFT && cnt == '0 && acc == '0)
    ) else $error("shift did not start the left pass");

endmodule

`default_nettype wire

// File: hdl/audio_fir_top.sv
`timescale 1ns/10ps
`default_nettype none

// Stereo output filter: coefficient store, sample history and MAC engine.
module audio_fir_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sample,
    input  audio_pkg::sample_t    left_in,
    input  audio_pkg::sample_t    right_in,
    input  logic                  coeff_we,
    input  fir_pkg::coeff_index_t coeff_addr,
    input  fir_pkg::coeff_t       coeff_data,
    output audio_pkg::out_t       left_out,
    output audio_pkg::out_t       right_out,
    output logic                  sample_out,
    output logic                  overrun
);

    logic                  shift;
    fir_pkg::tap_index_t   fwd_index;
    fir_pkg::tap_index_t   rev_index;
    fir_pkg::coeff_index_t coeff_index;
    fir_pkg::coeff_t       coeff_value;
    audio_pkg::sample_t    fwd_left;
    audio_pkg::sample_t    rev_left;
    audio_pkg::sample_t    fwd_right;
    audio_pkg::sample_t    rev_right;

    fir_coeff_regs coeff_regs (
        .clk         (clk),
        .rst         (rst),
        .coeff_we    (coeff_we),
        .coeff_addr  (coeff_addr),
        .coeff_data  (coeff_data),
        .coeff_index (coeff_index),
        .coeff_value (coeff_value)
    );

    fir_delay_line delay_line (
        .clk       (clk),
        .rst       (rst),
        .shift     (shift),
        .left_in   (left_in),
        .right_in  (right_in),
        .fwd_index (fwd_index),
        .rev_index (rev_index),
        .fwd_left  (fwd_left),
        .rev_left  (rev_left),
        .fwd_right (fwd_right),
        .rev_right (rev_right)
    );

    fir_mac_engine mac_engine (
        .clk         (clk),
        .rst         (rst),
        .sample      (sample),
        .fwd_left    (fwd_left),
        .rev_left    (rev_left),
        .fwd_right   (fwd_right),
        .rev_right   (rev_right),
        .coeff_value (coeff_value),
        .shift       (shift),
        .fwd_index   (fwd_index),
        .rev_index   (rev_index),
        .coeff_index (coeff_index),
        .left_out    (left_out),
        .right_out   (right_out),
        .sample_out  (sample_out),
        .overrun     (overrun)
    );

endmodule

`default_nettype wire

// File: verification/audio_fir_tb.sv
`timescale 1ns/10ps
`default_nettype none

// Directed testbench for the stereo FIR output filter.
module audio_fir_tb;

    localparam int     num_tests       = 6;
    localparam int     frames_per_test = 100;
    localparam int     frame_cycles    = 80;
    localparam int     clk_period      = 100;
    localparam int     latency         = 75;  // Detecting edge to sample_out.
    localparam longint watchdog_ns     =
        longint'(num_tests) * frames_per_test * frame_cycles * clk_period + 200000;

    logic                  clk;
    logic                  rst;
    logic                  sample;
    audio_pkg::sample_t    left_in;
    audio_pkg::sample_t    right_in;
    logic                  coeff_we;
    fir_pkg::coeff_index_t coeff_addr;
    fir_pkg::coeff_t       coeff_data;
    audio_pkg::out_t       left_out;
    audio_pkg::out_t       right_out;
    logic                  sample_out;
    logic                  overrun;

    // Reference model state.
    fir_pkg::coeff_t    m_coeff [fir_pkg::coeff_count];
    audio_pkg::sample_t m_left  [fir_pkg::taps];
    audio_pkg::sample_t m_right [fir_pkg::taps];

    int pass_count;
    int fail_count;
    int test_fail_base;

    audio_fir_top dut (
        .clk        (clk),
        .rst        (rst),
        .sample     (sample),
        .left_in    (left_in),
        .right_in   (right_in),
        .coeff_we   (coeff_we),
        .coeff_addr (coeff_addr),
        .coeff_data (coeff_data),
        .left_out   (left_out),
        .right_out  (right_out),
        .sample_out (sample_out),
        .overrun    (overrun)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before the tests finished");
        $display("sim failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    task automatic model_reset();
        for (int i = 0; i < fir_pkg::taps; i++) begin
            m_left[i]  = '0;
            m_right[i] = '0;
        end
        for (int k = 0; k < fir_pkg::coeff_count; k++) begin
            m_coeff[k] = fir_pkg::coeff_defaults[k];
        end
    endtask

    task automatic model_shift(input audio_pkg::sample_t l, input audio_pkg::sample_t r);
        for (int i = fir_pkg::taps - 1; i > 0; i--) begin
            m_left[i]  = m_left[i-1];
            m_right[i] = m_right[i-1];
        end
        m_left[0]  = l;  // Newest sample.
        m_right[0] = r;
    endtask

    // Symmetric sum per channel wrapped to the output width.
    function automatic audio_pkg::out_t model_sum(input bit right);
        int acc;
        int near_tap;
        int far_tap;
        acc = 0;
        for (int k = 0; k < fir_pkg::coeff_count; k++) begin
            near_tap = right ? int'(m_right[k]) : int'(m_left[k]);
            far_tap  = right ? int'(m_right[fir_pkg::taps-1-k]) : int'(m_left[fir_pkg::taps-1-k]);
            if (k == fir_pkg::coeff_count - 1) far_tap = 0;  // Centre tap counted once.
            acc += int'(m_coeff[k]) * (near_tap + far_tap);
        end
        return audio_pkg::out_t'(acc);
    endfunction

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_out(input string name, input audio_pkg::out_t expected,
                             input audio_pkg::out_t actual);
        if (actual !== expected) begin
            $display("ERROR %s expected 0x%h actual 0x%h", name, expected, actual);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_pulse(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s expected 0x%h actual 0x%h", name, expected, actual);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic report_test(input string name);
        if (fail_count == test_fail_base) $display("test %s finished, no errors", name);
        else $display("test %s finished, %0d errors", name, fail_count - test_fail_base);
        test_fail_base = fail_count;
    endtask

    // ------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_coeff(input int addr, input fir_pkg::coeff_t data);
        coeff_we   = 1'b1;
        coeff_addr = fir_pkg::coeff_index_t'(addr);
        coeff_data = data;
        next_cycle();
        coeff_we = 1'b0;
        if (addr < fir_pkg::coeff_count) m_coeff[addr] = data;  // Others are ignored.
    endtask

    // One frame of 80 cycles. With inject set, sample rises again mid-frame.
    task automatic run_frame(input audio_pkg::sample_t l, input audio_pkg::sample_t r,
                             input bit inject, output audio_pkg::out_t got_left,
                             output audio_pkg::out_t got_right);
        int n;
        bit done;
        audio_pkg::out_t exp_left;
        audio_pkg::out_t exp_right;
        model_shift(l, r);
        exp_left  = model_sum(1'b0);
        exp_right = model_sum(1'b1);
        left_in   = l;
        right_in  = r;
        sample    = 1'b1;
        n         = -1;
        done      = 1'b0;
        while (!done && n < latency + 20) begin
            next_cycle();
            n++;  // Zero at the detecting edge.
            if (n == 1) sample = 1'b0;
            if (inject && n == 10) begin
                sample   = 1'b1;
                left_in  = ~l;
                right_in = ~r;
            end
            if (inject && n == 11) sample = 1'b0;
            check_pulse("overrun", inject && n == 12, overrun);
            if (sample_out) done = 1'b1;
        end
        if (!done) begin
            $display("sample_out did not arrive within %0d cycles", latency + 20);
            fail_count++;
        end else begin
            if (n != latency) begin
                $display("sample_out came %0d edges after the detecting edge, not %0d",
                         n, latency);
                fail_count++;
            end
            check_out("left_out", exp_left, left_out);
            check_out("right_out", exp_right, right_out);
        end
        got_left  = left_out;
        got_right = right_out;
        repeat (frame_cycles - latency - 1) begin
            next_cycle();
            check_pulse("sample_out", 1'b0, sample_out);
            check_pulse("overrun", 1'b0, overrun);
        end
    endtask

    task automatic random_stream(input int count);
        audio_pkg::out_t gl;
        audio_pkg::out_t gr;
        repeat (count) begin
            run_frame(audio_pkg::sample_t'($urandom), audio_pkg::sample_t'($urandom),
                      1'b0, gl, gr);
        end
    endtask

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------
    task automatic test_reset_state();
        check_out("left_out", '0, left_out);
        check_out("right_out", '0, right_out);
        check_pulse("sample_out", 1'b0, sample_out);
        check_pulse("overrun", 1'b0, overrun);
        report_test("reset_state");
    endtask

    task automatic test_impulse();
        audio_pkg::out_t gl;
        audio_pkg::out_t gr;
        int idx;
        for (int j = 0; j < fir_pkg::taps; j++) begin
            run_frame((j == 0) ? 9'sd1 : 9'sd0, 9'sd0, 1'b0, gl, gr);
            idx = (j < fir_pkg::coeff_count) ? j : fir_pkg::taps - 1 - j;  // Mirrored.
            check_out("left_out", audio_pkg::out_t'(fir_pkg::coeff_defaults[idx]), gl);
            check_out("right_out", '0, gr);
        end
        report_test("impulse");
    endtask

    task automatic test_random_stream();
        random_stream(frames_per_test);
        report_test("random_stream");
    endtask

    task automatic test_coeff_writes();
        for (int a = 0; a < fir_pkg::coeff_count; a++) begin
            write_coeff(a, fir_pkg::coeff_t'($urandom));
        end
        write_coeff(40, fir_pkg::coeff_t'($urandom));  // Past the table.
        random_stream(40);
        report_test("coeff_writes");
    endtask

    task automatic test_overrun();
        audio_pkg::out_t gl;
        audio_pkg::out_t gr;
        run_frame(audio_pkg::sample_t'($urandom), audio_pkg::sample_t'($urandom), 1'b1, gl, gr);
        run_frame(audio_pkg::sample_t'($urandom), audio_pkg::sample_t'($urandom), 1'b0, gl, gr);
        report_test("overrun");
    endtask

    task automatic test_full_scale();
        audio_pkg::out_t gl;
        audio_pkg::out_t gr;
        for (int a = 0; a < fir_pkg::coeff_count; a++) begin
            write_coeff(a, a[0] ? 9'sd255 : -9'sd256);
        end
        for (int j = 0; j < 10; j++) begin
            run_frame(j[0] ? -9'sd256 : 9'sd255, j[0] ? 9'sd255 : -9'sd256, 1'b0, gl, gr);
        end
        report_test("full_scale");
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        void'($urandom(18));
        rst            = 1'b1;
        sample         = 1'b0;
        left_in        = '0;
        right_in       = '0;
        coeff_we       = 1'b0;
        coeff_addr     = '0;
        coeff_data     = '0;
        pass_count     = 0;
        fail_count     = 0;
        test_fail_base = 0;
        model_reset();
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;

        test_reset_state();
        test_impulse();
        test_random_stream();
        test_coeff_writes();
        test_overrun();
        test_full_scale();

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hdl/audio_pkg.sv
hdl/fir_pkg.sv
hdl/fir_coeff_regs.sv
hdl/fir_delay_line.sv
hdl/fir_mac_engine.sv
hdl/audio_fir_top.sv
verification/audio_fir_tb.sv

// File: Makefile
# Verilator build and run for the stereo FIR output filter.
TOP := audio_fir_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

obj_dir/V$(TOP): project.f $(wildcard hdl/*.sv) verification/audio_fir_tb.sv
	verilator --binary --timing --assert -j 0 -f project.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir
